/* rtl/flight_pkg.sv */
/*
 * Flight-control shared definitions
 * Stick, IMU, correction and motor types with their limits
 */
package flight_pkg;

    // Stick and motor scale
    localparam int unsigned STICK_MAX = 250;
    localparam int unsigned STICK_MID = 125;

    // Receiver pulse range in microseconds
    localparam int unsigned PULSE_MIN_US = 1000;
    localparam int unsigned PULSE_MAX_US = 2000;

    // Word widths
    localparam int unsigned STICK_W = 8;
    localparam int unsigned IMU_W   = 16;
    localparam int unsigned CORR_W  = 10;
    localparam int unsigned MOTOR_W = 8;

    // Decoded stick, 0 to STICK_MAX
    typedef logic [STICK_W-1:0] stick_t;

    // IMU angle or rate, two's complement
    typedef logic signed [IMU_W-1:0] imu_word_t;

    // Axis correction, held within +/- STICK_MAX
    typedef logic signed [CORR_W-1:0] corr_t;

    // Motor rate, 0 to STICK_MAX
    typedef logic [MOTOR_W-1:0] motor_rate_t;

    // Four receiver channels after decoding
    typedef struct packed {
        stick_t throttle;
        stick_t roll;
        stick_t pitch;
        stick_t yaw;
    } rc_sticks_t;

    // One IMU sample, yaw is rate only
    typedef struct packed {
        imu_word_t roll_angle;
        imu_word_t pitch_angle;
        imu_word_t roll_rate;
        imu_word_t pitch_rate;
        imu_word_t yaw_rate;
    } imu_sample_t;

    // Throttle passthrough plus three saturated corrections
    typedef struct packed {
        stick_t throttle;
        corr_t  roll;
        corr_t  pitch;
        corr_t  yaw;
    } axis_cmd_t;

    // X-frame motor rates
    typedef struct packed {
        motor_rate_t motor_1;
        motor_rate_t motor_2;
        motor_rate_t motor_3;
        motor_rate_t motor_4;
    } motor_rates_t;

endpackage

/* rtl/us_tick_gen.sv */
/*
 * Microsecond tick generator
 * One-cycle pulse every CLK_PER_US system clocks
 */
`timescale 1ns/100ps

module us_tick_gen #(
    parameter int unsigned CLK_PER_US = 50
) (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_tick
);
    // At least one bit even for a divide by one
    localparam int unsigned CNT_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_PER_US - 1);

    logic [CNT_W-1:0] div_cnt;

    // Divider wraps on the last count, tick marks the wrap
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            div_cnt <= '0;
            us_tick <= 1'b0;
        end else begin
            us_tick <= (div_cnt == CNT_LAST);
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Isolated ticks whenever the divider is real
    a_tick_single: assert property (@(posedge sys_clk) disable iff (!resetn)
        (CLK_PER_US > 1) && us_tick |=> !us_tick);

endmodule

/* rtl/rc_pulse_decoder.sv */
/*
 * Receiver channel decoder
 * Measures one pulse in microseconds, maps 1000..2000 us onto 0..250
 */
`timescale 1ns/100ps

module rc_pulse_decoder import flight_pkg::*; (
    input  logic   sys_clk,
    input  logic   resetn,
    input  logic   us_tick,
    input  logic   rc_pwm,
    output stick_t stick
);
    // Counter just wide enough for the longest valid pulse
    localparam int unsigned PW_W = $clog2(PULSE_MAX_US + 1);
    localparam logic [PW_W-1:0] PW_MIN = PW_W'(PULSE_MIN_US);
    localparam logic [PW_W-1:0] PW_MAX = PW_W'(PULSE_MAX_US);
    localparam logic [PW_W-3:0] QUARTER_MAX = (PW_W-2)'(STICK_MAX);

    logic            pwm_meta;
    logic            pwm_sync;
    logic            pwm_prev;
    logic            pwm_fall;
    logic [PW_W-1:0] width_us;
    logic [PW_W-1:0] excess_us;
    logic [PW_W-3:0] quarter;
    stick_t          stick_next;

    // Two-flop synchronizer, then one more stage for edge detect
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            pwm_meta <= 1'b0;
            pwm_sync <= 1'b0;
            pwm_prev <= 1'b0;
        end else begin
            pwm_meta <= rc_pwm;
            pwm_sync <= pwm_meta;
            pwm_prev <= pwm_sync;
        end
    end

    assign pwm_fall = pwm_prev & ~pwm_sync;

    // High time in microseconds, held at the top of the range
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            width_us <= '0;
        end else if (!pwm_sync) begin
            width_us <= '0;
        end else if (us_tick && (width_us < PW_MAX)) begin
            width_us <= width_us + 1'b1;
        end
    end

    // Short pulses floor at zero
    assign excess_us = (width_us > PW_MIN) ? (width_us - PW_MIN) : '0;

    // Four microseconds per stick step
    assign quarter = excess_us[PW_W-1:2];
    assign stick_next = (quarter > QUARTER_MAX) ? stick_t'(STICK_MAX) : quarter[STICK_W-1:0];

    // Value is a level, refreshed on each falling edge
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            stick <= '0;
        end else if (pwm_fall) begin
            stick <= stick_next;
        end
    end

    // Decoded value never leaves the stick scale
    a_stick_range: assert property (@(posedge sys_clk) disable iff (!resetn)
        stick <= STICK_MAX);

endmodule

/* rtl/attitude_controller.sv */
/*
 * Attitude controller, two pipeline stages
 * Angle error to target rate, rate error to saturated axis correction
 */
`timescale 1ns/100ps

module attitude_controller import flight_pkg::*; #(
    parameter int unsigned ANGLE_SHIFT = 1,
    parameter int unsigned RATE_SHIFT  = 2
) (
    input  logic        sys_clk,
    input  logic        resetn,
    input  logic        imu_valid,
    input  imu_sample_t imu,
    input  rc_sticks_t  sticks,
    output logic        cmd_valid,
    output axis_cmd_t   cmd
);
    // Two guard bits: stick minus angle, then target minus rate
    localparam int unsigned ERR_W = IMU_W + 2;
    typedef logic signed [ERR_W-1:0] err_t;

    localparam err_t  ERR_HI  = err_t'(STICK_MAX);
    localparam err_t  ERR_LO  = -err_t'(STICK_MAX);
    localparam corr_t CORR_HI = corr_t'(STICK_MAX);
    localparam corr_t CORR_LO = -corr_t'(STICK_MAX);

    // Centre stick at zero
    function automatic err_t stick_offset(input stick_t v);
        return err_t'({1'b0, v}) - err_t'(STICK_MID);
    endfunction

    // Clamp to the correction range
    function automatic corr_t saturate(input err_t v);
        corr_t r;
        if (v > ERR_HI) begin
            r = CORR_HI;
        end else if (v < ERR_LO) begin
            r = CORR_LO;
        end else begin
            r = corr_t'(v);
        end
        return r;
    endfunction

    err_t   roll_target;
    err_t   pitch_target;
    logic   s1_valid;
    stick_t s1_throttle;
    err_t   s1_roll_target;
    err_t   s1_pitch_target;
    err_t   s1_yaw_target;
    err_t   s1_roll_rate;
    err_t   s1_pitch_rate;
    err_t   s1_yaw_rate;
    err_t   roll_err;
    err_t   pitch_err;
    err_t   yaw_err;

    // Angle loop, arithmetic shift floors negative values
    assign roll_target  = (stick_offset(sticks.roll) - err_t'(imu.roll_angle)) >>> ANGLE_SHIFT;
    assign pitch_target = (stick_offset(sticks.pitch) - err_t'(imu.pitch_angle)) >>> ANGLE_SHIFT;

    // Stage one strobe
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= imu_valid;
        end
    end

    // Stage one payload, loaded per sample
    always_ff @(posedge sys_clk) begin
        if (imu_valid) begin
            s1_throttle     <= sticks.throttle;
            s1_roll_target  <= roll_target;
            s1_pitch_target <= pitch_target;
            // Yaw has no angle loop, stick is the rate target
            s1_yaw_target   <= stick_offset(sticks.yaw);
            s1_roll_rate    <= err_t'(imu.roll_rate);
            s1_pitch_rate   <= err_t'(imu.pitch_rate);
            s1_yaw_rate     <= err_t'(imu.yaw_rate);
        end
    end

    // Rate loop, scaled down by the rate gain
    assign roll_err  = (s1_roll_target - s1_roll_rate) >>> RATE_SHIFT;
    assign pitch_err = (s1_pitch_target - s1_pitch_rate) >>> RATE_SHIFT;
    assign yaw_err   = (s1_yaw_target - s1_yaw_rate) >>> RATE_SHIFT;

    // Stage two, command held until the next sample
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            cmd_valid <= 1'b0;
            cmd       <= '0;
        end else begin
            cmd_valid <= s1_valid;
            if (s1_valid) begin
                cmd.throttle <= s1_throttle;
                cmd.roll     <= saturate(roll_err);
                cmd.pitch    <= saturate(pitch_err);
                cmd.yaw      <= saturate(yaw_err);
            end
        end
    end

    // Fixed two-cycle latency, back-to-back samples included
    a_cmd_latency: assert property (@(posedge sys_clk) disable iff (!resetn)
        imu_valid |-> ##2 cmd_valid);
    a_cmd_source: assert property (@(posedge sys_clk) disable iff (!resetn)
        cmd_valid |-> $past(imu_valid, 2));

    // Corrections stay inside the motor scale
    a_corr_range: assert property (@(posedge sys_clk) disable iff (!resetn)
        (cmd.roll <= CORR_HI) && (cmd.roll >= CORR_LO) &&
        (cmd.pitch <= CORR_HI) && (cmd.pitch >= CORR_LO) &&
        (cmd.yaw <= CORR_HI) && (cmd.yaw >= CORR_LO));

endmodule

/* rtl/motor_mixer.sv */
/*
 * X-frame motor mixer
 * Throttle plus roll, pitch and yaw corrections into four clamped motor rates
 */
`timescale 1ns/100ps

module motor_mixer import flight_pkg::*; (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         cmd_valid,
    input  axis_cmd_t    cmd,
    output logic         motor_valid,
    output motor_rates_t motors
);
    // Worst case 250 + 3 * 250, two guard bits over a correction
    localparam int unsigned MIX_W = CORR_W + 2;
    typedef logic signed [MIX_W-1:0] mix_t;

    localparam mix_t MIX_MAX = mix_t'(STICK_MAX);

    // Clamp a signed sum to the motor scale
    function automatic motor_rate_t clamp_rate(input mix_t v);
        motor_rate_t r;
        if (v < 0) begin
            r = '0;
        end else if (v > MIX_MAX) begin
            r = motor_rate_t'(STICK_MAX);
        end else begin
            r = motor_rate_t'(v);
        end
        return r;
    endfunction

    mix_t thr;
    mix_t roll_c;
    mix_t pitch_c;
    mix_t yaw_c;
    mix_t mix_1;
    mix_t mix_2;
    mix_t mix_3;
    mix_t mix_4;

    // Throttle is unsigned, corrections sign-extend
    assign thr     = mix_t'({1'b0, cmd.throttle});
    assign roll_c  = mix_t'(cmd.roll);
    assign pitch_c = mix_t'(cmd.pitch);
    assign yaw_c   = mix_t'(cmd.yaw);

    // X-frame mix, diagonal pairs share the yaw sign
    assign mix_1 = thr + pitch_c + roll_c - yaw_c;
    assign mix_2 = thr + pitch_c - roll_c + yaw_c;
    assign mix_3 = thr - pitch_c - roll_c - yaw_c;
    assign mix_4 = thr - pitch_c + roll_c + yaw_c;

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            motor_valid <= 1'b0;
            motors      <= '0;
        end else begin
            motor_valid <= cmd_valid;
            if (cmd_valid) begin
                motors.motor_1 <= clamp_rate(mix_1);
                motors.motor_2 <= clamp_rate(mix_2);
                motors.motor_3 <= clamp_rate(mix_3);
                motors.motor_4 <= clamp_rate(mix_4);
            end
        end
    end

    // No motor rate above full scale
    a_rate_range: assert property (@(posedge sys_clk) disable iff (!resetn)
        (motors.motor_1 <= STICK_MAX) && (motors.motor_2 <= STICK_MAX) &&
        (motors.motor_3 <= STICK_MAX) && (motors.motor_4 <= STICK_MAX));

endmodule

/* rtl/esc_pwm_generator.sv */
/*
 * ESC pulse generator for four motors
 * One pulse per frame, 1000 us plus 4 us per rate step
 */
`timescale 1ns/100ps

module esc_pwm_generator import flight_pkg::*; #(
    parameter int unsigned FRAME_US = 2500
) (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         us_tick,
    input  logic         motor_valid,
    input  motor_rates_t motors,
    output logic [3:0]   esc_pwm
);
    localparam int unsigned FRM_W = $clog2(FRAME_US);
    localparam logic [FRM_W-1:0] FRAME_LAST = FRM_W'(FRAME_US - 1);
    localparam logic [FRM_W-1:0] PULSE_BASE = FRM_W'(PULSE_MIN_US);

    // End of the high phase within the frame
    function automatic logic [FRM_W-1:0] pulse_end(input motor_rate_t rate);
        return PULSE_BASE + FRM_W'({rate, 2'b00});
    endfunction

    motor_rates_t     rates_hold;
    motor_rates_t     rates_frame;
    logic [FRM_W-1:0] frame_us;
    logic             running;
    logic             frame_start;
    logic [3:0]       pulse_on;

    // Newest mixer output, a later one overwrites
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            rates_hold <= '0;
        end else if (motor_valid) begin
            rates_hold <= motors;
        end
    end

    // First tick after reset opens frame zero
    assign frame_start = us_tick && (!running || (frame_us == FRAME_LAST));

    // Frame counter, rates frozen for the whole frame
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            running     <= 1'b0;
            frame_us    <= '0;
            rates_frame <= '0;
        end else if (frame_start) begin
            running     <= 1'b1;
            frame_us    <= '0;
            rates_frame <= rates_hold;
        end else if (us_tick) begin
            frame_us <= frame_us + 1'b1;
        end
    end

    // High from frame start until the motor's pulse end
    assign pulse_on[0] = running && (frame_us < pulse_end(rates_frame.motor_1));
    assign pulse_on[1] = running && (frame_us < pulse_end(rates_frame.motor_2));
    assign pulse_on[2] = running && (frame_us < pulse_end(rates_frame.motor_3));
    assign pulse_on[3] = running && (frame_us < pulse_end(rates_frame.motor_4));

    // Registered pins, glitch free toward the ESCs
    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            esc_pwm <= '0;
        end else begin
            esc_pwm <= pulse_on;
        end
    end

    // A full-scale pulse must fit inside a frame
    a_frame_len: assert property (@(posedge sys_clk) disable iff (!resetn)
        FRAME_US > PULSE_MAX_US);

endmodule

/* rtl/flight_controller_top.sv */
/*
 * Quadcopter flight-control datapath
 * Receiver decode, attitude loops, X-frame mixer and ESC pulses
 */
`timescale 1ns/100ps

module flight_controller_top import flight_pkg::*; #(
    parameter int unsigned CLK_PER_US  = 50,
    parameter int unsigned FRAME_US    = 2500,
    parameter int unsigned ANGLE_SHIFT = 1,
    parameter int unsigned RATE_SHIFT  = 2
) (
    input  logic        sys_clk,
    input  logic        resetn,
    input  logic        throttle_pwm,
    input  logic        roll_pwm,
    input  logic        pitch_pwm,
    input  logic        yaw_pwm,
    input  logic        imu_valid,
    input  imu_sample_t imu,
    output logic [3:0]  esc_pwm
);
    logic         us_tick;
    stick_t       throttle_val;
    stick_t       roll_val;
    stick_t       pitch_val;
    stick_t       yaw_val;
    rc_sticks_t   sticks;
    logic         cmd_valid;
    axis_cmd_t    cmd;
    logic         motor_valid;
    motor_rates_t motors;

    // Shared microsecond time base
    us_tick_gen #(.CLK_PER_US(CLK_PER_US)) i_us_tick_gen (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .us_tick (us_tick)
    );

    // One decoder per receiver channel
    rc_pulse_decoder i_rc_throttle (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .us_tick (us_tick),
        .rc_pwm  (throttle_pwm),
        .stick   (throttle_val)
    );
    rc_pulse_decoder i_rc_roll (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .us_tick (us_tick),
        .rc_pwm  (roll_pwm),
        .stick   (roll_val)
    );
    rc_pulse_decoder i_rc_pitch (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .us_tick (us_tick),
        .rc_pwm  (pitch_pwm),
        .stick   (pitch_val)
    );
    rc_pulse_decoder i_rc_yaw (
        .sys_clk (sys_clk),
        .resetn  (resetn),
        .us_tick (us_tick),
        .rc_pwm  (yaw_pwm),
        .stick   (yaw_val)
    );

    assign sticks = '{throttle: throttle_val, roll: roll_val, pitch: pitch_val, yaw: yaw_val};

    // Runs once per IMU sample
    attitude_controller #(
        .ANGLE_SHIFT (ANGLE_SHIFT),
        .RATE_SHIFT  (RATE_SHIFT)
    ) i_attitude_controller (
        .sys_clk   (sys_clk),
        .resetn    (resetn),
        .imu_valid (imu_valid),
        .imu       (imu),
        .sticks    (sticks),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    motor_mixer i_motor_mixer (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .motor_valid (motor_valid),
        .motors      (motors)
    );

    // Pins follow the mixer from the next frame start
    esc_pwm_generator #(.FRAME_US(FRAME_US)) i_esc_pwm_generator (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .us_tick     (us_tick),
        .motor_valid (motor_valid),
        .motors      (motors),
        .esc_pwm     (esc_pwm)
    );

endmodule

/* dv/tb_flight_controller.sv */
/*
 * Flight controller testbench
 * Directed receiver and IMU stimulus, ESC pulse widths checked against a reference model
 */
`timescale 1ns/100ps

module tb_flight_controller import flight_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int CLK_PER_US  = 5;
    localparam int FRAME_US    = 2500;
    localparam int ANGLE_SHIFT = 1;
    localparam int RATE_SHIFT  = 2;
    localparam int SMAX        = STICK_MAX;
    localparam int SMID        = STICK_MID;
    localparam int PMIN        = PULSE_MIN_US;
    localparam int PMAX        = PULSE_MAX_US;

    // Idle, throttle, 3 correction, 2 saturation and 20 random measurements
    localparam int NUM_RUNS    = 27;
    localparam longint WATCHDOG_NS =
        longint'(NUM_RUNS * 4 + 8) * FRAME_US * CLK_PER_US * CLK_PERIOD;

    logic        sys_clk = 1'b0;
    logic        resetn;
    logic        throttle_pwm;
    logic        roll_pwm;
    logic        pitch_pwm;
    logic        yaw_pwm;
    logic        imu_valid;
    imu_sample_t imu;
    logic [3:0]  esc_pwm;

    int seed = 32'h761abd56;
    int cur_w [4];
    int meas_us [4];

    flight_controller_top #(
        .CLK_PER_US  (CLK_PER_US),
        .FRAME_US    (FRAME_US),
        .ANGLE_SHIFT (ANGLE_SHIFT),
        .RATE_SHIFT  (RATE_SHIFT)
    ) i_flight_controller_top (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .throttle_pwm (throttle_pwm),
        .roll_pwm     (roll_pwm),
        .pitch_pwm    (pitch_pwm),
        .yaw_pwm      (yaw_pwm),
        .imu_valid    (imu_valid),
        .imu          (imu),
        .esc_pwm      (esc_pwm)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // Receiver width to stick, 4 us per step
    function automatic int decode_us(input int w);
        int v;
        v = (w > PMAX) ? PMAX : w;
        v = (v > PMIN) ? (v - PMIN) / 4 : 0;
        return (v > SMAX) ? SMAX : v;
    endfunction

    // Rate error scaled and held to +/- full scale
    function automatic int axis_corr(input int target, input int rate);
        int c;
        c = (target - rate) >>> RATE_SHIFT;
        if (c > SMAX) begin
            c = SMAX;
        end else if (c < -SMAX) begin
            c = -SMAX;
        end
        return c;
    endfunction

    function automatic motor_rate_t clamp_motor(input int v);
        return motor_rate_t'((v < 0) ? 0 : ((v > SMAX) ? SMAX : v));
    endfunction

    // Decode, attitude loops and X-frame mix
    function automatic motor_rates_t model_rates(input int w_thr, input int w_roll,
                                                 input int w_pitch, input int w_yaw,
                                                 input imu_sample_t s);
        int thr;
        int c_roll;
        int c_pitch;
        int c_yaw;
        motor_rates_t r;
        thr     = decode_us(w_thr);
        c_roll  = axis_corr((decode_us(w_roll) - SMID - int'(s.roll_angle)) >>> ANGLE_SHIFT,
                            int'(s.roll_rate));
        c_pitch = axis_corr((decode_us(w_pitch) - SMID - int'(s.pitch_angle)) >>> ANGLE_SHIFT,
                            int'(s.pitch_rate));
        // Yaw stick is the rate target directly
        c_yaw   = axis_corr(decode_us(w_yaw) - SMID, int'(s.yaw_rate));
        r.motor_1 = clamp_motor(thr + c_pitch + c_roll - c_yaw);
        r.motor_2 = clamp_motor(thr + c_pitch - c_roll + c_yaw);
        r.motor_3 = clamp_motor(thr - c_pitch - c_roll - c_yaw);
        r.motor_4 = clamp_motor(thr - c_pitch + c_roll + c_yaw);
        return r;
    endfunction

    function automatic imu_sample_t make_imu(input int ra, input int pa, input int rr,
                                             input int pr, input int yr);
        imu_sample_t s;
        s.roll_angle  = imu_word_t'(ra);
        s.pitch_angle = imu_word_t'(pa);
        s.roll_rate   = imu_word_t'(rr);
        s.pitch_rate  = imu_word_t'(pr);
        s.yaw_rate    = imu_word_t'(yr);
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_pulse_us(input int motor, input int exp_us, input int got_us);
        if (got_us != exp_us) begin
            stop_on_error($sformatf("motor %0d pulse %0d us, expected %0d us",
                                    motor + 1, got_us, exp_us));
        end
    endtask

    // Rates from the measured widths, then the exact widths for off-step residues
    task automatic check_motor_rates(input motor_rates_t exp_rates, input string what);
        motor_rates_t got;
        got.motor_1 = motor_rate_t'((meas_us[0] - PMIN) / 4);
        got.motor_2 = motor_rate_t'((meas_us[1] - PMIN) / 4);
        got.motor_3 = motor_rate_t'((meas_us[2] - PMIN) / 4);
        got.motor_4 = motor_rate_t'((meas_us[3] - PMIN) / 4);
        if (got !== exp_rates) begin
            stop_on_error($sformatf("%s: rates %h, expected %h", what, got, exp_rates));
        end
        check_pulse_us(0, PMIN + 4 * int'(exp_rates.motor_1), meas_us[0]);
        check_pulse_us(1, PMIN + 4 * int'(exp_rates.motor_2), meas_us[1]);
        check_pulse_us(2, PMIN + 4 * int'(exp_rates.motor_3), meas_us[2]);
        check_pulse_us(3, PMIN + 4 * int'(exp_rates.motor_4), meas_us[3]);
    endtask

    // All four channels start together, each drops after its own width
    task automatic drive_rc_pulses(input int w_thr, input int w_roll,
                                   input int w_pitch, input int w_yaw);
        int n_thr;
        int n_roll;
        int n_pitch;
        int n_yaw;
        int n_max;
        n_thr   = w_thr * CLK_PER_US;
        n_roll  = w_roll * CLK_PER_US;
        n_pitch = w_pitch * CLK_PER_US;
        n_yaw   = w_yaw * CLK_PER_US;
        n_max   = n_thr;
        n_max   = (n_roll > n_max) ? n_roll : n_max;
        n_max   = (n_pitch > n_max) ? n_pitch : n_max;
        n_max   = (n_yaw > n_max) ? n_yaw : n_max;
        @(posedge sys_clk);
        throttle_pwm <= 1'b1;
        roll_pwm     <= 1'b1;
        pitch_pwm    <= 1'b1;
        yaw_pwm      <= 1'b1;
        for (int n = 1; n <= n_max; n++) begin
            @(posedge sys_clk);
            if (n == n_thr) throttle_pwm <= 1'b0;
            if (n == n_roll) roll_pwm <= 1'b0;
            if (n == n_pitch) pitch_pwm <= 1'b0;
            if (n == n_yaw) yaw_pwm <= 1'b0;
        end
        // Synchronizer plus decode register
        repeat (8) @(posedge sys_clk);
        cur_w = '{w_thr, w_roll, w_pitch, w_yaw};
    endtask

    task automatic send_imu(input imu_sample_t s);
        @(posedge sys_clk);
        imu       <= s;
        imu_valid <= 1'b1;
        @(posedge sys_clk);
        imu_valid <= 1'b0;
    endtask

    // High time of each pin over the next frame, sampled mid-cycle
    task automatic measure_esc;
        int cnt [4];
        cnt = '{0, 0, 0, 0};
        do @(negedge sys_clk); while (esc_pwm != 4'b0000);
        do @(negedge sys_clk); while (esc_pwm == 4'b0000);
        while (esc_pwm != 4'b0000) begin
            for (int i = 0; i < 4; i++) begin
                if (esc_pwm[i]) cnt[i]++;
            end
            @(negedge sys_clk);
        end
        for (int i = 0; i < 4; i++) begin
            meas_us[i] = cnt[i] / CLK_PER_US;
        end
    endtask

    // New rates show from the next frame start, so skip one frame
    task automatic run_sample(input imu_sample_t s, input string what);
        motor_rates_t exp_rates;
        exp_rates = model_rates(cur_w[0], cur_w[1], cur_w[2], cur_w[3], s);
        send_imu(s);
        measure_esc();
        measure_esc();
        check_motor_rates(exp_rates, what);
    endtask

    task automatic test_idle_after_reset;
        measure_esc();
        check_motor_rates('0, "idle frame 1");
        measure_esc();
        check_motor_rates('0, "idle frame 2");
    endtask

    task automatic test_throttle_decode;
        motor_rates_t exp_rates;
        // 1400 us throttle is rate 100, neutral sticks add nothing
        exp_rates = '{default: motor_rate_t'(100)};
        drive_rc_pulses(1400, 1500, 1500, 1500);
        send_imu(make_imu(0, 0, 0, 0, 0));
        measure_esc();
        measure_esc();
        check_motor_rates(exp_rates, "throttle decode");
    endtask

    task automatic test_roll_pitch_correction;
        run_sample(make_imu(40, 0, 0, -30, 13), "correction 1");
        run_sample(make_imu(-37, 0, 0, 21, -9), "correction 2");
        run_sample(make_imu(15, -22, 7, -3, 5), "correction 3");
    endtask

    task automatic test_saturation;
        drive_rc_pulses(2300, 800, 2150, 950);
        run_sample(make_imu(32767, -32768, -20000, 20000, 30000), "saturation 1");
        drive_rc_pulses(900, 2200, 700, 2050);
        run_sample(make_imu(-32768, 32767, 32767, -32768, -30000), "saturation 2");
    endtask

    task automatic test_random_samples;
        int w [4];
        imu_sample_t s;
        for (int k = 0; k < 20; k++) begin
            for (int i = 0; i < 4; i++) begin
                w[i] = 900 + int'($unsigned($random(seed)) % 1300);
            end
            s = make_imu($random(seed) % 400, $random(seed) % 400, $random(seed) % 600,
                         $random(seed) % 600, $random(seed) % 600);
            drive_rc_pulses(w[0], w[1], w[2], w[3]);
            run_sample(s, $sformatf("random sample %0d", k));
        end
    endtask

    initial begin
        resetn       <= 1'b0;
        throttle_pwm <= 1'b0;
        roll_pwm     <= 1'b0;
        pitch_pwm    <= 1'b0;
        yaw_pwm      <= 1'b0;
        imu_valid    <= 1'b0;
        imu          <= '0;
        cur_w        = '{0, 0, 0, 0};
        repeat (16) @(posedge sys_clk);
        resetn <= 1'b1;

        test_idle_after_reset();
        test_throttle_decode();
        test_roll_pitch_correction();
        test_saturation();
        test_random_samples();

        $display("Simulation passed");
        $finish;
    end

    // Run length bound, about four frames per measurement
    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired, the simulation timed out");
        $display("Simulation failed");
        $fatal(1, "watchdog");
    end

endmodule

/* filelist.f */
rtl/flight_pkg.sv
rtl/us_tick_gen.sv
rtl/rc_pulse_decoder.sv
rtl/attitude_controller.sv
rtl/motor_mixer.sv
rtl/esc_pwm_generator.sv
rtl/flight_controller_top.sv
dv/tb_flight_controller.sv

/* Bender.yml */
package:
  name: flight_controller

sources:
  - files:
      - rtl/flight_pkg.sv
      - rtl/us_tick_gen.sv
      - rtl/rc_pulse_decoder.sv
      - rtl/attitude_controller.sv
      - rtl/motor_mixer.sv
      - rtl/esc_pwm_generator.sv
      - rtl/flight_controller_top.sv
  - target: test
    files:
      - dv/tb_flight_controller.sv
